// ==== design/ps2_kbd_pkg.sv ====
package ps2_kbd_pkg;

    // Raw byte from the keyboard, make code or prefix
    typedef logic [7:0] scan_code_t;

    typedef logic [7:0] ascii_t;

    // Active low, bit 6 is segment a and bit 0 is segment g
    typedef logic [6:0] seg7_t;

    // Distinct key presses, 0 to 99
    typedef logic [6:0] press_cnt_t;

    localparam scan_code_t BREAK_PREFIX = 8'hF0;
    localparam scan_code_t EXT_PREFIX   = 8'hE0;
    localparam press_cnt_t PRESS_MAX    = 7'd99;

    // idle_st   no key held
    // held_st   a make code is held
    // break_st  F0 seen, next byte is the released key
    typedef enum logic [1:0] {
        idle_st,
        held_st,
        break_st
    } ctrl_state_t;

endpackage

// ==== design/scan_fifo_if.sv ====
interface scan_fifo_if
    import ps2_kbd_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
);

    // Read and write pointers carry one wrap bit above the address
    localparam int PTR_W = $clog2(FIFO_DEPTH) + 1;

    logic       push;
    scan_code_t wdata;
    logic       pop;
    scan_code_t rdata;
    logic       empty;
    logic       full;

    if (FIFO_DEPTH != (1 << (PTR_W - 1))) begin : g_depth_check
        $error("scan_fifo_if: FIFO_DEPTH must be a power of two");
    end

    modport ctrl (output push, wdata, pop, input empty);
    modport fifo (input push, wdata, pop, output rdata, empty, full);

endinterface

// ==== design/ps2_frame_rx.sv ====
module ps2_frame_rx
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output scan_code_t code,
    output logic       code_valid,
    output logic       frame_error
);

    logic [2:0] clk_sync;
    logic [2:0] data_sync;
    logic       clk_prev;
    logic       fall;
    logic       data_bit;
    logic       last_bit;
    logic       frame_ok;
    logic [3:0] bit_cnt;

    // Start, eight data bits LSB first, parity
    logic [9:0] frame_bits;

    // Both lines idle high, so the synchronizer resets to ones
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[1:0], ps2_data};
            clk_prev  <= clk_sync[2];
        end
    end

    assign fall     = clk_prev & ~clk_sync[2];
    assign data_bit = data_sync[2];
    assign last_bit = (bit_cnt == 4'd10);

    // Stop bit is the live sample on the 11th edge
    assign frame_ok = !frame_bits[0] && (^frame_bits[9:1]) && data_bit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt <= '0;
                    if (frame_ok) begin
                        code_valid <= 1'b1;
                    end else begin
                        frame_error <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && !last_bit) begin
            frame_bits <= {data_bit, frame_bits[9:1]};
        end
        if (fall && last_bit && frame_ok) begin
            code <= frame_bits[8:1];
        end
    end

    // Frames are at least 11 slow edges apart
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        code_valid |=> !code_valid
    );

endmodule

// ==== design/scan_fifo.sv ====
module scan_fifo
    import ps2_kbd_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    scan_fifo_if.fifo fifo_port,
    output logic      overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    scan_code_t    mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign fifo_port.empty = (wr_ptr == rd_ptr);
    assign fifo_port.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                             (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Show-ahead head
    assign fifo_port.rdata = mem[rd_ptr[AW-1:0]];

    // A pop in the same cycle frees the slot for a push into a full FIFO
    assign do_push = fifo_port.push && (!fifo_port.full || fifo_port.pop);
    assign do_pop  = fifo_port.pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= fifo_port.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (fifo_port.push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    // Pop is built from ready in the control block
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_port.pop |-> !fifo_port.empty
    );

endmodule

// ==== design/key_event_ctrl.sv ====
module key_event_ctrl
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  scan_code_t code,
    input  logic       code_valid,
    input  logic       next_n,
    scan_fifo_if.ctrl  fifo_port,
    output logic       ready,
    output press_cnt_t press_count
);

    ctrl_state_t state;
    scan_code_t  held_code;
    logic        is_break;
    logic        is_ext;
    logic        is_make;
    logic        is_repeat;

    assign is_break  = (code == BREAK_PREFIX);
    assign is_ext    = (code == EXT_PREFIX);
    assign is_make   = code_valid && !is_break && !is_ext && (state != break_st);

    // Typematic repeat of the key still held
    assign is_repeat = (state == held_st) && (code == held_code);

    assign fifo_port.push  = is_make;
    assign fifo_port.wdata = code;

    assign ready         = !fifo_port.empty;
    assign fifo_port.pop = ready && !next_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle_st;
            press_count <= '0;
        end else if (code_valid && !is_ext) begin
            if (is_break) begin
                state <= break_st;
            end else if (state == break_st) begin
                // Released key, dropped
                state <= idle_st;
            end else begin
                state <= held_st;
                if (!is_repeat && press_count != PRESS_MAX) begin
                    press_count <= press_count + 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_make) begin
            held_code <= code;
        end
    end

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        press_count <= PRESS_MAX
    );

endmodule

// ==== design/scan_to_ascii.sv ====
module scan_to_ascii
    import ps2_kbd_pkg::*;
(
    input  scan_code_t code,
    output ascii_t     ascii
);

    // Scan set 2, unshifted
    always_comb begin
        case (code)
            8'h1C:   ascii = "a";
            8'h32:   ascii = "b";
            8'h21:   ascii = "c";
            8'h23:   ascii = "d";
            8'h24:   ascii = "e";
            8'h2B:   ascii = "f";
            8'h34:   ascii = "g";
            8'h33:   ascii = "h";
            8'h43:   ascii = "i";
            8'h3B:   ascii = "j";
            8'h42:   ascii = "k";
            8'h4B:   ascii = "l";
            8'h3A:   ascii = "m";
            8'h31:   ascii = "n";
            8'h44:   ascii = "o";
            8'h4D:   ascii = "p";
            8'h15:   ascii = "q";
            8'h2D:   ascii = "r";
            8'h1B:   ascii = "s";
            8'h2C:   ascii = "t";
            8'h3C:   ascii = "u";
            8'h2A:   ascii = "v";
            8'h1D:   ascii = "w";
            8'h22:   ascii = "x";
            8'h35:   ascii = "y";
            8'h1A:   ascii = "z";
            // Top row digits
            8'h45:   ascii = "0";
            8'h16:   ascii = "1";
            8'h1E:   ascii = "2";
            8'h26:   ascii = "3";
            8'h25:   ascii = "4";
            8'h2E:   ascii = "5";
            8'h36:   ascii = "6";
            8'h3D:   ascii = "7";
            8'h3E:   ascii = "8";
            8'h46:   ascii = "9";
            8'h29:   ascii = " ";
            // Enter gives carriage return
            8'h5A:   ascii = 8'h0D;
            default: ascii = 8'h00;
        endcase
    end

endmodule

// ==== design/seg7_display.sv ====
module seg7_display
    import ps2_kbd_pkg::*;
(
    input  scan_code_t key_code,
    input  ascii_t     key_ascii,
    input  logic       blank,
    input  press_cnt_t press_count,
    output seg7_t      seg0,
    output seg7_t      seg1,
    output seg7_t      seg2,
    output seg7_t      seg3,
    output seg7_t      seg4,
    output seg7_t      seg5
);

    press_cnt_t tens;
    press_cnt_t units;

    // Order a..g, low lights the segment
    function automatic seg7_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b0000001;
            4'h1:    return 7'b1001111;
            4'h2:    return 7'b0010010;
            4'h3:    return 7'b0000110;
            4'h4:    return 7'b1001100;
            4'h5:    return 7'b0100100;
            4'h6:    return 7'b0100000;
            4'h7:    return 7'b0001111;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0000100;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b1100000;
            4'hC:    return 7'b0110001;
            4'hD:    return 7'b1000010;
            4'hE:    return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    assign seg0 = blank ? '1 : hex_to_seg(key_code[3:0]);
    assign seg1 = blank ? '1 : hex_to_seg(key_code[7:4]);
    assign seg2 = blank ? '1 : hex_to_seg(key_ascii[3:0]);
    assign seg3 = blank ? '1 : hex_to_seg(key_ascii[7:4]);

    // Count is at most 99, so both digits fit in a nibble
    assign tens  = press_count / 7'd10;
    assign units = press_count % 7'd10;

    assign seg4 = hex_to_seg(units[3:0]);
    assign seg5 = hex_to_seg(tens[3:0]);

endmodule

// ==== design/ps2_kbd_top.sv ====
module ps2_kbd_top
    import ps2_kbd_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       next_n,
    output scan_code_t key_code,
    output ascii_t     key_ascii,
    output logic       ready,
    output logic       overflow,
    output logic       frame_error,
    output press_cnt_t press_count,
    output seg7_t      seg0,
    output seg7_t      seg1,
    output seg7_t      seg2,
    output seg7_t      seg3,
    output seg7_t      seg4,
    output seg7_t      seg5
);

    scan_code_t rx_code;
    logic       rx_valid;

    scan_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_if ();

    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (rx_code),
        .code_valid  (rx_valid),
        .frame_error (frame_error)
    );

    key_event_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .code        (rx_code),
        .code_valid  (rx_valid),
        .next_n      (next_n),
        .fifo_port   (fifo_if.ctrl),
        .ready       (ready),
        .press_count (press_count)
    );

    scan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .fifo_port (fifo_if.fifo),
        .overflow  (overflow)
    );

    assign key_code = fifo_if.rdata;

    scan_to_ascii u_ascii (
        .code  (key_code),
        .ascii (key_ascii)
    );

    seg7_display u_display (
        .key_code    (key_code),
        .key_ascii   (key_ascii),
        .blank       (~ready),
        .press_count (press_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

endmodule

// ==== tests/ps2_kbd_tb.sv ====
module ps2_kbd_tb
    import ps2_kbd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH = 8;
    localparam int HALF       = 12;
    localparam int GAP        = 8;
    localparam int N_ACT      = 80;
    localparam int MAX_FRAMES = 2 * N_ACT + PRESS_MAX + FIFO_DEPTH + 20;
    localparam int TIMEOUT    = MAX_FRAMES * 11 * 2 * HALF + 2000;

    logic clk, rst_n, ps2_clk, ps2_data, next_n;
    scan_code_t key_code;
    ascii_t     key_ascii;
    logic       ready, overflow, frame_error;
    press_cnt_t press_count;
    seg7_t      seg0, seg1, seg2, seg3, seg4, seg5;

    // Reference model
    scan_code_t exp_q [$];
    scan_code_t pop_log [$];
    scan_code_t m_held_code;
    int         m_count = 0;
    bit         m_held = 0, m_in_break = 0, m_ovf = 0, m_ferr = 0;

    // Frame handed from the PS/2 driver to the model
    bit         ev_pending = 0, ev_good;
    int         ev_cycle;
    scan_code_t ev_code;

    int cycle_cnt = 0;
    int host_mode = 1;
    int seed = 32'h1639;

    scan_code_t key_set [7] = '{8'h1C, 8'h32, 8'h45, 8'h29, 8'h5A, 8'h76, 8'h16};
    scan_code_t letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
        8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    scan_code_t digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
        8'h3D, 8'h3E, 8'h46};
    // Lit segments a..g, active high
    logic [6:0] lit_pattern [16] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F,
        7'h70, 7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};

    ps2_kbd_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
        .clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .next_n(next_n), .key_code(key_code), .key_ascii(key_ascii), .ready(ready),
        .overflow(overflow), .frame_error(frame_error), .press_count(press_count),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4), .seg5(seg5)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
            $display("TB FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic ascii_t expected_ascii(input scan_code_t c);
        ascii_t a;
        a = 8'h00;
        for (int i = 0; i < 26; i++)
            if (letter_codes[i] == c) a = 8'h61 + 8'(i);
        for (int i = 0; i < 10; i++)
            if (digit_codes[i] == c) a = 8'h30 + 8'(i);
        if (c == 8'h29) a = 8'h20;
        if (c == 8'h5A) a = 8'h0D;
        return a;
    endfunction

    function automatic seg7_t expected_seg(input logic [3:0] nib);
        return ~lit_pattern[nib];
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_outputs();
        ascii_t a;
        assert (ready === (exp_q.size() != 0))
            else report_error($sformatf("ready %b, expected %0d items", ready, exp_q.size()));
        if (exp_q.size() != 0) begin
            a = expected_ascii(exp_q[0]);
            assert (key_code === exp_q[0])
                else report_error($sformatf("key_code %h, expected %h", key_code, exp_q[0]));
            assert (key_ascii === a)
                else report_error($sformatf("key_ascii %h, expected %h", key_ascii, a));
            assert ({seg3, seg2, seg1, seg0} === {expected_seg(a[7:4]), expected_seg(a[3:0]),
                    expected_seg(exp_q[0][7:4]), expected_seg(exp_q[0][3:0])})
                else report_error($sformatf("seg0..seg3 wrong for code %h", exp_q[0]));
        end else begin
            assert ({seg3, seg2, seg1, seg0} === '1)
                else report_error("seg0..seg3 not blank while FIFO empty");
        end
        assert (press_count === 7'(m_count))
            else report_error($sformatf("press_count %0d, expected %0d", press_count, m_count));
        assert ({seg5, seg4} === {expected_seg(4'(m_count / 10)), expected_seg(4'(m_count % 10))})
            else report_error($sformatf("seg4/seg5 wrong for count %0d", m_count));
        assert (overflow === m_ovf)
            else report_error($sformatf("overflow %b, expected %b", overflow, m_ovf));
        assert (frame_error === m_ferr)
            else report_error($sformatf("frame_error %b, expected %b", frame_error, m_ferr));
    endtask

    task automatic apply_frame(input scan_code_t c, input bit good);
        if (!good) begin
            m_ferr = 1;
        end else if (c == BREAK_PREFIX) begin
            m_in_break = 1;
        end else if (c == EXT_PREFIX) begin
            // Extended prefix is dropped
        end else if (m_in_break) begin
            m_in_break = 0;
            m_held = 0;
        end else begin
            if (exp_q.size() < FIFO_DEPTH) exp_q.push_back(c);
            else m_ovf = 1;
            if (!(m_held && c == m_held_code) && m_count < PRESS_MAX) m_count++;
            m_held = 1;
            m_held_code = c;
        end
    endtask

    // Outputs are stable mid-cycle; pops and pushes land on the next edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_outputs();
            if (ready && !next_n) pop_log.push_back(key_code);
            if (exp_q.size() != 0 && !next_n) void'(exp_q.pop_front());
            if (ev_pending && cycle_cnt == ev_cycle) begin
                ev_pending = 0;
                apply_frame(ev_code, ev_good);
            end
        end
    end

    task automatic send_frame(input scan_code_t b, input bit good);
        logic [10:0] bits;
        bits = {1'b1, (~^b) ^ !good, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            wait_cycles(HALF / 2);
            ps2_data = bits[i];
            wait_cycles(HALF / 2);
            ps2_clk = 1'b0;
            if (i == 10) begin
                // 3 sync stages plus edge detect, then the code_valid cycle
                ev_code = b;
                ev_good = good;
                ev_cycle = cycle_cnt + (good ? 4 : 3);
                ev_pending = 1;
            end
            wait_cycles(HALF);
            ps2_clk = 1'b1;
        end
        wait_cycles(GAP);
    endtask

    // Host side, draws off the driver's time slot
    initial begin
        int r;
        int mode;
        next_n = 1'b1;
        forever begin
            @(posedge clk);
            #0.5;
            r = {$random(seed)} % 32;
            mode = host_mode;
            #0.5;
            if (mode == 0) next_n = (r != 0);
            else next_n = (mode == 1);
        end
    end

    initial begin
        int         action;
        scan_code_t key, last_key;
        scan_code_t ovf_codes [$];
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        last_key = key_set[0];
        wait_cycles(3);
        rst_n = 1'b1;
        wait_cycles(1);
        assert (!ready && !overflow && !frame_error && press_count == 0)
            else report_error("outputs not in reset state after reset");
        host_mode = 0;
        send_frame(8'h1C, 0);
        assert (frame_error === 1'b1) else report_error("bad parity frame not flagged");
        for (int n = 0; n < N_ACT; n++) begin
            action = {$random(seed)} % 16;
            key = key_set[{$random(seed)} % 7];
            if (action < 7 || action > 12) begin
                send_frame(key, 1);
                last_key = key;
            end else if (action < 9) begin
                send_frame(last_key, 1);
            end else if (action < 11) begin
                send_frame(BREAK_PREFIX, 1);
                send_frame(last_key, 1);
            end else if (action == 11) begin
                send_frame(EXT_PREFIX, 1);
                send_frame(key, 1);
                last_key = key;
            end else begin
                send_frame(key, 0);
            end
        end
        // Distinct keys until the counter saturates
        for (int i = 0; m_count < PRESS_MAX || i < 3; i++) send_frame(key_set[i % 7], 1);
        host_mode = 2;
        while (exp_q.size() != 0) wait_cycles(1);
        host_mode = 1;
        wait_cycles(2);
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            ovf_codes.push_back(key_set[i % 7]);
            send_frame(key_set[i % 7], 1);
        end
        assert (overflow === 1'b1) else report_error("overflow not set on a full FIFO");
        pop_log.delete();
        host_mode = 2;
        while (exp_q.size() != 0) wait_cycles(1);
        wait_cycles(2);
        assert (pop_log.size() == FIFO_DEPTH)
            else report_error($sformatf("%0d codes popped after overflow", pop_log.size()));
        for (int i = 0; i < FIFO_DEPTH; i++)
            assert (pop_log[i] === ovf_codes[i])
                else report_error($sformatf("popped %h, expected %h", pop_log[i], ovf_codes[i]));
        assert (press_count == PRESS_MAX) else report_error("press count did not saturate");
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== ps2_kbd_top.f ====
design/ps2_kbd_pkg.sv
design/scan_fifo_if.sv
design/ps2_frame_rx.sv
design/scan_fifo.sv
design/key_event_ctrl.sv
design/scan_to_ascii.sv
design/seg7_display.sv
design/ps2_kbd_top.sv
tests/ps2_kbd_tb.sv
